// File: src/ec_mod_pkg.sv
`default_nettype none

package ec_mod_pkg;

   // *************************************************
   // widths and pipeline timing
   // *************************************************
   localparam int word_w      = 256;
   localparam int limb_w      = 32;
   localparam int add_stages  = 8;             // ppn_add latency in cycles.
   localparam int job_latency = 17;            // count value that loads the result.
   localparam int cmd_depth   = 4;
   localparam int res_depth   = 4;

   typedef logic [word_w-1:0] word_t;

   // *************************************************
   // curve25519 moduli
   // *************************************************
   localparam word_t p_mod =
      256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;
   localparam word_t n_mod =
      256'h10000000_00000000_00000000_00000000_14def9de_a2f79cd6_5812631a_5cf5d3ed;
   localparam word_t p_comp =
      256'h80000000_00000000_00000000_00000000_00000000_00000000_00000000_00000013;
   localparam word_t n_comp =
      256'hefffffff_ffffffff_ffffffff_ffffffff_eb210621_5d086329_a7ed9ce5_a30a2c13;

   typedef enum logic [1:0] {
      op_add_p = 2'b00,
      op_add_n = 2'b01,
      op_sub_p = 2'b10,                        // high bit selects subtraction.
      op_sub_n = 2'b11
   } mod_op_t;

   typedef struct packed {
      mod_op_t op;
      word_t   a;
      word_t   b;
   } mod_cmd_t;

endpackage

`default_nettype wire

// File: src/mod_job_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mod_job_if import ec_mod_pkg::*; ();

   logic    start;                             // held high for the whole job.
   mod_op_t op;
   word_t   a;
   word_t   b;
   word_t   result;
   logic    done;                              // one cycle pulse with result.

   modport issuer (
      output start, op, a, b,
      input  result, done
   );

   modport worker (
      input  start, op, a, b,
      output result, done
   );

endinterface

`default_nettype wire

// File: src/ppn_add.sv
`timescale 1ns/1ps
`default_nettype none

module ppn_add import ec_mod_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  word_t a,
   input  word_t b,
   input  logic  cin,
   output word_t sum,
   output logic  cout
);

   word_t              a_d [1:add_stages-1];     // operands delayed by the stage index.
   word_t              b_d [1:add_stages-1];
   word_t              op_a [add_stages];
   word_t              op_b [add_stages];
   word_t              ps_next [add_stages];
   word_t              ps_q [add_stages];        // partial sums, low limbs filled in.
   logic [limb_w:0]    limb_sum [add_stages];
   logic [add_stages-1:0] c_in;
   logic [add_stages-1:0] c_q;

   always_comb begin
      op_a[0]    = a;
      op_b[0]    = b;
      c_in[0]    = cin;
      ps_next[0] = '0;
      for (int k = 1; k < add_stages; k++) begin
         op_a[k]    = a_d[k];
         op_b[k]    = b_d[k];
         c_in[k]    = c_q[k-1];
         ps_next[k] = ps_q[k-1];
      end
      for (int k = 0; k < add_stages; k++) begin
         limb_sum[k] = {1'b0, op_a[k][k*limb_w +: limb_w]}
                     + {1'b0, op_b[k][k*limb_w +: limb_w]}
                     + {{limb_w{1'b0}}, c_in[k]};
         ps_next[k][k*limb_w +: limb_w] = limb_sum[k][limb_w-1:0];
      end
   end

   always_ff @(posedge clk) begin
      for (int k = 1; k < add_stages; k++) begin
         a_d[k] <= op_a[k-1];
         b_d[k] <= op_b[k-1];
      end
      for (int k = 0; k < add_stages; k++) begin
         ps_q[k] <= ps_next[k];
      end
   end

   // the carry ripples one stage per cycle.
   always_ff @(posedge clk) begin
      if (reset) begin
         c_q <= '0;
      end else begin
         for (int k = 0; k < add_stages; k++) begin
            c_q[k] <= limb_sum[k][limb_w];
         end
      end
   end

   assign sum  = ps_q[add_stages-1];
   assign cout = c_q[add_stages-1];

endmodule

`default_nettype wire

// File: src/mod_add_sub.sv
`timescale 1ns/1ps
`default_nettype none

module mod_add_sub import ec_mod_pkg::*; (
   input logic       clk,
   input logic       reset,
   mod_job_if.worker job
);

   word_t                 a_q;
   word_t                 b_q;
   mod_op_t               op_q;
   logic [4:0]            count;
   word_t                 b_in;
   word_t                 mod_k;
   word_t                 sum1;
   word_t                 sum2;
   logic                  c1;
   logic                  c2;
   word_t                 sum1_d [add_stages];
   logic [add_stages-1:0] c1_d;
   word_t                 sum1_dly;
   logic                  c1_dly;
   logic                  use_corr;
   logic                  last_cycle;

   always_ff @(posedge clk) begin
      if (job.start) begin
         a_q  <= job.a;
         b_q  <= job.b;
         op_q <= job.op;
      end
   end

   // *************************************************
   // first adder forms a + b or a - b
   // *************************************************
   assign b_in = op_q[1] ? ~b_q : b_q;          // two's complement with carry in.

   ppn_add add_1_i (
      .clk   (clk),
      .reset (reset),
      .a     (a_q),
      .b     (b_in),
      .cin   (op_q[1]),
      .sum   (sum1),
      .cout  (c1)
   );

   // *************************************************
   // second adder applies the modulus correction
   // *************************************************
   always_comb begin
      case (op_q)
         op_add_p: mod_k = p_comp;               // subtracting p by adding 2^256 - p.
         op_add_n: mod_k = n_comp;
         op_sub_p: mod_k = p_mod;
         default:  mod_k = n_mod;
      endcase
   end

   ppn_add add_2_i (
      .clk   (clk),
      .reset (reset),
      .a     (sum1),
      .b     (mod_k),
      .cin   (1'b0),
      .sum   (sum2),
      .cout  (c2)
   );

   // align the uncorrected value with the second adder output.
   always_ff @(posedge clk) begin
      sum1_d[0] <= sum1;
      for (int i = 1; i < add_stages; i++) begin
         sum1_d[i] <= sum1_d[i-1];
      end
      c1_d <= {c1_d[add_stages-2:0], c1};
   end

   assign sum1_dly = sum1_d[add_stages-1];
   assign c1_dly   = c1_d[add_stages-1];

   // a missing carry on subtraction is a borrow.
   assign use_corr   = op_q[1] ? !c1_dly : (c1_dly || c2);
   assign last_cycle = job.start && (count == 5'(job_latency));

   always_ff @(posedge clk) begin
      if (reset) begin
         count    <= '0;
         job.done <= 1'b0;
      end else begin
         count    <= job.start ? count + 5'd1 : 5'd0;
         job.done <= last_cycle;
      end
   end

   always_ff @(posedge clk) begin
      if (last_cycle) begin
         job.result <= use_corr ? sum2 : sum1_dly;
      end
   end

   // the issuer holds start until it has seen done, so no job is cut short.
   a_start_held : assert property (@(posedge clk) disable iff (reset)
      $fell(job.start) |-> $past(job.done))
      else $error("start dropped before done.");

endmodule

`default_nettype wire

// File: src/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter type payload_t = logic [31:0],
   parameter int  depth     = 4
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     wr,
   input  payload_t wr_data,
   output logic     full,
   input  logic     rd,
   output payload_t rd_data,
   output logic     empty
);

   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);

   payload_t        mem [depth];
   logic [aw-1:0]   wr_ptr;
   logic [aw-1:0]   rd_ptr;
   logic [cw-1:0]   count;
   logic            do_wr;
   logic            do_rd;

   assign do_wr = wr && !full;
   assign do_rd = rd && !empty;

   always_ff @(posedge clk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_wr && !do_rd) begin
            count <= count + 1'b1;
         end else if (do_rd && !do_wr) begin
            count <= count - 1'b1;
         end
      end
   end

   assign rd_data = mem[rd_ptr];               // oldest entry is always on show.
   assign full    = (count == cw'(depth));
   assign empty   = (count == '0);

   a_no_overflow : assert property (@(posedge clk) disable iff (reset) wr |-> !full)
      else $error("write into a full queue.");
   a_no_underflow : assert property (@(posedge clk) disable iff (reset) rd |-> !empty)
      else $error("read from an empty queue.");

endmodule

`default_nettype wire

// File: src/mod_job_seq.sv
`timescale 1ns/1ps
`default_nettype none

module mod_job_seq import ec_mod_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  mod_cmd_t   cmd,
   input  logic       cmd_empty,
   output logic       cmd_rd,
   input  logic       res_full,
   output logic       res_wr,
   output word_t      res_data,
   mod_job_if.issuer  job
);

   typedef enum logic {
      st_idle,
      st_busy
   } state_t;

   state_t   state;
   mod_cmd_t cmd_q;

   // room is checked at pop time, so the push on done always fits.
   assign cmd_rd   = (state == st_idle) && !cmd_empty && !res_full;
   assign res_wr   = (state == st_busy) && job.done;
   assign res_data = job.result;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         case (state)
            st_idle: begin
               if (cmd_rd) begin
                  state <= st_busy;
               end
            end
            st_busy: begin
               if (job.done) begin
                  state <= st_idle;                // start falls the cycle after done.
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_rd) begin
         cmd_q <= cmd;
      end
   end

   assign job.start = (state == st_busy);
   assign job.op    = cmd_q.op;
   assign job.a     = cmd_q.a;
   assign job.b     = cmd_q.b;

   a_done_when_busy : assert property (@(posedge clk) disable iff (reset)
      job.done |-> (state == st_busy))
      else $error("done seen with no job in flight.");

endmodule

`default_nettype wire

// File: src/ec_mod_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ec_mod_unit import ec_mod_pkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  logic    cmd_wr,
   input  mod_op_t cmd_op,
   input  word_t   cmd_a,
   input  word_t   cmd_b,
   output logic    cmd_full,
   input  logic    res_rd,
   output word_t   res_data,
   output logic    res_empty
);

   mod_cmd_t cmd_in;
   mod_cmd_t cmd_head;
   logic     cmd_empty;
   logic     cmd_rd;
   logic     res_full;
   logic     res_wr;
   word_t    seq_res;

   mod_job_if job ();

   assign cmd_in = '{op: cmd_op, a: cmd_a, b: cmd_b};

   // *************************************************
   // command queue, sequencer and modular adder
   // *************************************************
   sync_fifo #(
      .payload_t (mod_cmd_t),
      .depth     (cmd_depth)
   ) cmd_q_i (
      .clk     (clk),
      .reset   (reset),
      .wr      (cmd_wr),
      .wr_data (cmd_in),
      .full    (cmd_full),
      .rd      (cmd_rd),
      .rd_data (cmd_head),
      .empty   (cmd_empty)
   );

   mod_job_seq seq_i (
      .clk       (clk),
      .reset     (reset),
      .cmd       (cmd_head),
      .cmd_empty (cmd_empty),
      .cmd_rd    (cmd_rd),
      .res_full  (res_full),
      .res_wr    (res_wr),
      .res_data  (seq_res),
      .job       (job.issuer)
   );

   mod_add_sub mod_i (
      .clk   (clk),
      .reset (reset),
      .job   (job.worker)
   );

   sync_fifo #(
      .payload_t (word_t),
      .depth     (res_depth)
   ) res_q_i (
      .clk     (clk),
      .reset   (reset),
      .wr      (res_wr),
      .wr_data (seq_res),
      .full    (res_full),
      .rd      (res_rd),
      .rd_data (res_data),
      .empty   (res_empty)
   );

endmodule

`default_nettype wire

// File: sim/tb_ec_mod_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ec_mod_unit import ec_mod_pkg::*; ();

   localparam int wait_limit  = 2000;           // cycles allowed for any single wait.
   localparam int stall_limit = 60;             // several job lengths with cmd_full high.

   logic    clk;
   logic    reset;
   logic    cmd_wr;
   mod_op_t cmd_op;
   word_t   cmd_a;
   word_t   cmd_b;
   logic    cmd_full;
   logic    res_rd;
   word_t   res_data;
   logic    res_empty;

   word_t   exp_q [$];                          // expected results in command order.
   string   test_name;
   logic    read_en;
   logic    read_gaps;
   logic    timed_out;
   int      error_count;
   int      test_errors;
   int      tests_passed;
   int      tests_failed;

   ec_mod_unit dut_i (
      .clk       (clk),
      .reset     (reset),
      .cmd_wr    (cmd_wr),
      .cmd_op    (cmd_op),
      .cmd_a     (cmd_a),
      .cmd_b     (cmd_b),
      .cmd_full  (cmd_full),
      .res_rd    (res_rd),
      .res_data  (res_data),
      .res_empty (res_empty)
   );

   always #10 clk = ~clk;

   // *************************************************
   // reference model and helpers
   // *************************************************
   function automatic word_t modulus_of(mod_op_t op);
      return op[0] ? n_mod : p_mod;
   endfunction

   function automatic word_t mod_ref(mod_op_t op, word_t a, word_t b);
      logic [word_w:0] m;
      logic [word_w:0] r;
      m = {1'b0, modulus_of(op)};
      if (op[1]) begin
         r = {1'b0, a} - {1'b0, b};
         if (a < b) begin
            r = r + m;                          // wraps back into the field.
         end
      end else begin
         r = {1'b0, a} + {1'b0, b};
         if (r >= m) begin
            r = r - m;
         end
      end
      return r[word_w-1:0];
   endfunction

   function automatic word_t rand_below(word_t m);
      word_t r;
      for (int i = 0; i < 8; i++) begin
         r[i*32 +: 32] = $urandom;
      end
      return r % m;
   endfunction

   task automatic check_value(string name, word_t expected, word_t actual);
      if (expected !== actual) begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         error_count++;
      end
   endtask

   task automatic report_failure(string msg);
      $display("%s: %s", test_name, msg);
      error_count++;
   endtask

   task automatic report_timeout(string what);
      $display("timeout waiting for %s in test %s", what, test_name);
      timed_out = 1'b1;
      error_count++;
   endtask

   task automatic begin_test(string name);
      test_name   = name;
      test_errors = error_count;
   endtask

   task automatic end_test();
      if (error_count == test_errors) begin
         tests_passed++;
         $display("test %s: pass", test_name);
      end else begin
         tests_failed++;
         $display("test %s: fail with %0d errors", test_name, error_count - test_errors);
      end
   endtask

   // *************************************************
   // command side
   // *************************************************
   task automatic issue_write(mod_op_t op, word_t a, word_t b);
      @(posedge clk);
      cmd_wr <= 1'b1;
      cmd_op <= op;
      cmd_a  <= a;
      cmd_b  <= b;
      exp_q.push_back(mod_ref(op, a, b));
      @(posedge clk);
      cmd_wr <= 1'b0;                           // the queue took it on this edge.
   endtask

   task automatic send_cmd(mod_op_t op, word_t a, word_t b);
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (cmd_full && !timed_out) begin
         if (cycles >= wait_limit) begin
            report_timeout("room in the command queue");
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
      if (!timed_out) begin
         issue_write(op, a, b);
      end
   endtask

   task automatic wait_drain();
      int cycles;
      cycles = 0;
      while (exp_q.size() != 0 && !timed_out) begin
         if (cycles >= wait_limit) begin
            report_timeout("a result");
         end else begin
            cycles++;
            @(negedge clk);
         end
      end
   endtask

   task automatic run_add_cases(mod_op_t op);
      word_t m;
      m = modulus_of(op);
      send_cmd(op, 256'd5, 256'd7);
      send_cmd(op, m - 256'd1, 256'd1);         // sum equals the modulus.
      send_cmd(op, m - 256'd10, 256'd10);
      send_cmd(op, m - 256'd3, 256'd10);
      send_cmd(op, m - 256'd1, m - 256'd1);
      wait_drain();
   endtask

   task automatic run_sub_cases(mod_op_t op);
      word_t m;
      m = modulus_of(op);
      send_cmd(op, m - 256'd1, 256'd12345);
      send_cmd(op, 256'hdead_beef, 256'hdead_beef);
      send_cmd(op, 256'd3, m - 256'd4);         // borrow, wraps to 7.
      send_cmd(op, 256'd0, m - 256'd1);
      wait_drain();
   endtask

   task automatic send_random_cmd();
      mod_op_t op;
      word_t   m;
      op = mod_op_t'($urandom_range(0, 3));
      m  = modulus_of(op);
      send_cmd(op, rand_below(m), rand_below(m));
   endtask

   task automatic run_back_pressure();
      int      accepted;
      int      stall;
      int      steps;
      mod_op_t op;
      word_t   m;
      accepted = 0;
      stall    = 0;
      steps    = 0;
      read_en  = 1'b0;
      while (stall < stall_limit && steps < wait_limit) begin
         @(negedge clk);
         steps++;
         if (cmd_full) begin
            stall++;
         end else begin
            stall = 0;
            op    = mod_op_t'($urandom_range(0, 3));
            m     = modulus_of(op);
            issue_write(op, rand_below(m), rand_below(m));
            accepted++;
         end
      end
      if (stall < stall_limit) begin
         report_failure("cmd_full never stayed high while results were left unread");
      end
      if (accepted < cmd_depth + res_depth) begin
         report_failure($sformatf("only %0d commands accepted before the queues filled",
                                  accepted));
      end
      read_en = 1'b1;
      wait_drain();
   endtask

   // *************************************************
   // result reader and comparison
   // *************************************************
   always begin
      @(negedge clk);
      if (read_en && !res_empty) begin
         if (exp_q.size() == 0) begin
            report_failure("a result appeared with no command outstanding");
         end else begin
            check_value(test_name, exp_q.pop_front(), res_data);
         end
         @(posedge clk);
         res_rd <= 1'b1;
         @(posedge clk);
         res_rd <= 1'b0;                        // pop happens on this edge.
         if (read_gaps) begin
            repeat ($urandom_range(0, 8)) @(negedge clk);
         end
      end
   end

   initial begin
      void'($urandom(32'h5953));
      clk          = 1'b0;
      reset        = 1'b1;
      cmd_wr       = 1'b0;
      cmd_op       = op_add_p;
      cmd_a        = '0;
      cmd_b        = '0;
      res_rd       = 1'b0;
      read_en      = 1'b0;
      read_gaps    = 1'b0;
      timed_out    = 1'b0;
      error_count  = 0;
      tests_passed = 0;
      tests_failed = 0;
      test_name    = "reset";
      repeat (2) @(posedge clk);
      reset <= 1'b0;

      begin_test("reset_state");
      @(negedge clk);
      check_value("reset_state res_empty", word_t'(1), word_t'(res_empty));
      check_value("reset_state cmd_full", word_t'(0), word_t'(cmd_full));
      end_test();

      read_en = 1'b1;
      begin_test("add_mod_p");
      run_add_cases(op_add_p);
      end_test();
      begin_test("add_mod_n");
      run_add_cases(op_add_n);
      end_test();
      begin_test("sub_mod_p");
      run_sub_cases(op_sub_p);
      end_test();
      begin_test("sub_mod_n");
      run_sub_cases(op_sub_n);
      end_test();

      begin_test("random_sequence");
      for (int i = 0; i < 200; i++) begin
         send_random_cmd();
      end
      wait_drain();
      end_test();

      begin_test("back_pressure");
      run_back_pressure();
      end_test();

      begin_test("interleaved");
      read_gaps = 1'b1;
      for (int i = 0; i < 40; i++) begin
         repeat ($urandom_range(0, 6)) @(posedge clk);
         send_random_cmd();
      end
      wait_drain();
      end_test();

      $display("tests passed %0d, tests failed %0d, errors %0d",
               tests_passed, tests_failed, error_count);
      if (tests_failed == 0 && error_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
src/ec_mod_pkg.sv
src/mod_job_if.sv
src/ppn_add.sv
src/mod_add_sub.sv
src/sync_fifo.sv
src/mod_job_seq.sv
src/ec_mod_unit.sv
sim/tb_ec_mod_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then judge the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f compile.f --top-module tb_ec_mod_unit \
   -Mdir obj_dir -o tb_ec_mod_unit
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/tb_ec_mod_unit > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
   exit 0
fi
exit 1
